// ==== test/trace_golden.mem ====
// One cycle per line, hex. Core 0 then core 1 stimulus: valid pc insn wben wbreg wbdata
// Then expected per core two cycles later: putc_valid putc_char exited exit_code instret
// Last column is the expected all_done
1 100 04800193 1 3 48  1 200 04f00193 1 3 4f  0 0 0 0 2  0 0 0 0 1  0
1 104 05a00293 1 5 5a  0 0 00000000 0 0 0  0 0 0 0 3  0 0 0 0 2  0
1 108 00400013 0 0 0  1 204 00400013 0 0 0  1 48 0 0 4  1 4f 0 0 3  0
1 10c 06900193 1 3 69  1 208 06b00193 1 3 6b  0 48 0 0 5  0 4f 0 0 4  0
1 110 00400013 0 0 0  1 20c 00400013 0 0 0  1 69 0 0 5  1 6b 0 0 5  0
0 0 00000000 0 0 0  1 210 123451b7 1 3 12345000  0 69 0 0 6  0 6b 0 0 6  0
1 114 00400093 1 1 4  1 214 07818193 1 3 12345078  0 69 0 0 7  0 6b 0 0 7  0
1 118 00200013 0 0 0  1 218 00400013 0 0 0  0 69 0 0 7  1 78 0 0 8  0
0 11c 00400013 0 0 0  1 21c 00000013 0 0 0  0 69 0 0 8  0 78 0 0 8  0
1 11c 00418013 0 0 0  0 0 00000000 0 0 0  0 69 0 0 9  0 78 0 0 9  0
1 120 00404013 0 0 0  1 220 00000013 0 0 0  0 69 0 0 a  0 78 0 0 9  0
1 124 02100393 1 7 21  0 0 00000000 0 0 0  0 69 0 0 b  0 78 0 0 9  0
1 128 00400013 0 0 0  0 0 00000000 0 0 0  1 69 0 0 c  0 78 0 0 a  0
1 12c 00a00193 1 3 a  1 224 02100193 1 3 21  0 69 0 0 d  0 78 0 0 b  0
1 130 00400013 0 0 0  1 228 00400013 0 0 0  1 a 0 0 e  1 21 0 0 b  0
1 134 02a00193 1 3 2a  0 0 00000000 0 0 0  0 a 0 0 f  0 21 0 0 b  0
1 138 00100013 0 0 0  0 0 00000000 0 0 0  0 a 1 2a f  0 21 0 0 b  0
1 13c 00400013 0 0 0  0 0 00000000 0 0 0  0 a 1 2a f  0 21 0 0 c  0
1 140 05500193 1 3 55  1 22c 00000013 0 0 0  0 a 1 2a f  0 21 0 0 d  0
1 144 00100013 0 0 0  1 230 00000013 0 3 ee  0 a 1 2a f  0 21 0 0 d  0
1 148 00400013 0 0 0  0 0 00000000 1 3 ff  0 a 1 2a f  0 21 0 0 e  0
0 0 00000000 0 0 0  1 234 00400013 0 0 0  0 a 1 2a f  1 21 0 0 f  0
0 0 00000000 0 0 0  1 238 00000013 0 0 0  0 a 1 2a f  0 21 0 0 10  0
1 14c 00000013 0 0 0  1 23c beef01b7 1 3 beef0000  0 a 1 2a f  0 21 0 0 11  0
0 0 00000000 0 0 0  1 240 00100013 0 0 0  0 a 1 2a f  0 21 1 beef0000 11  0
0 0 00000000 0 0 0  1 244 00400013 0 0 0  0 a 1 2a f  0 21 1 beef0000 11  1
0 0 00000000 0 0 0  1 248 00000013 0 0 0  0 a 1 2a f  0 21 1 beef0000 11  1
0 0 00000000 0 0 0  1 24c 00100013 0 0 0  0 a 1 2a f  0 21 1 beef0000 11  1
0 0 00000000 0 0 0  0 0 00000000 0 0 0  0 a 1 2a f  0 21 1 beef0000 11  1
0 0 00000000 0 0 0  0 0 00000000 0 0 0  0 a 1 2a f  0 21 1 beef0000 11  1
0 0 00000000 0 0 0  0 0 00000000 0 0 0  0 a 1 2a f  0 21 1 beef0000 11  1
0 0 00000000 0 0 0  0 0 00000000 0 0 0  0 a 1 2a f  0 21 1 beef0000 11  1
0 0 00000000 0 0 0  0 0 00000000 0 0 0  0 a 1 2a f  0 21 1 beef0000 11  1
0 0 00000000 0 0 0  0 0 00000000 0 0 0  0 a 1 2a f  0 21 1 beef0000 11  1
0 0 00000000 0 0 0  0 0 00000000 0 0 0  0 a 1 2a f  0 21 1 beef0000 11  1
0 0 00000000 0 0 0  0 0 00000000 0 0 0  0 a 1 2a f  0 21 1 beef0000 11  1

// ==== src.f ====
common/trace_pkg.sv
common/sim_event_pkg.sv
rtl/r3_shadow.sv
rtl/sim_event_decode.sv
rtl/core_trace_monitor.sv
rtl/termination_tracker.sv
rtl/trace_monitor_top.sv
test/tb_trace_monitor.sv

// ==== test/tb_trace_monitor.sv ====
`timescale 1ns/1ns
`default_nettype none

// Replays golden retire records into the trace monitor and checks its outputs
module tb_trace_monitor
  import trace_pkg::*;
  import sim_event_pkg::*;
();

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 5;

  // Golden file layout, one 32-bit word per column
  localparam int NUM_RECS  = 36;
  localparam int STIM_COLS = 6;
  localparam int EXP_COLS  = 5;
  localparam int EXP_BASE  = NUM_CORES * STIM_COLS;
  localparam int DONE_COL  = EXP_BASE + NUM_CORES * EXP_COLS;
  localparam int NUM_COLS  = DONE_COL + 1;

  // Stimulus columns within one core's group
  localparam int COL_VALID  = 0;
  localparam int COL_PC     = 1;
  localparam int COL_INSN   = 2;
  localparam int COL_WBEN   = 3;
  localparam int COL_WBREG  = 4;
  localparam int COL_WBDATA = 5;

  // Expected columns within one core's group
  localparam int EXP_PUTC    = 0;
  localparam int EXP_CHAR    = 1;
  localparam int EXP_EXITED  = 2;
  localparam int EXP_CODE    = 3;
  localparam int EXP_INSTRET = 4;

  // Outputs for record k are sampled two cycles after it is driven
  localparam int OUT_LAG     = 2;
  localparam int CYCLE_LIMIT = NUM_RECS + 20;

  logic clk;
  logic rst_n;

  logic [NUM_CORES-1:0]           trace_valid;
  logic [NUM_CORES*XLEN-1:0]      trace_pc;
  logic [NUM_CORES*XLEN-1:0]      trace_insn;
  logic [NUM_CORES-1:0]           trace_wben;
  logic [NUM_CORES*REG_IDX_W-1:0] trace_wbreg;
  logic [NUM_CORES*XLEN-1:0]      trace_wbdata;

  logic [NUM_CORES-1:0]           putc_valid;
  logic [NUM_CORES*CHAR_W-1:0]    putc_char;
  logic [NUM_CORES-1:0]           exited;
  logic [NUM_CORES*XLEN-1:0]      exit_code;
  logic [NUM_CORES*INSTRET_W-1:0] instret;
  logic                           all_done;

  logic [31:0] golden [0:NUM_RECS*NUM_COLS-1];

  int error_count;
  int check_count;
  int cycle_count;

  trace_monitor_top trace_monitor_top_inst (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .trace_valid_i  (trace_valid),
    .trace_pc_i     (trace_pc),
    .trace_insn_i   (trace_insn),
    .trace_wben_i   (trace_wben),
    .trace_wbreg_i  (trace_wbreg),
    .trace_wbdata_i (trace_wbdata),
    .putc_valid_o   (putc_valid),
    .putc_char_o    (putc_char),
    .exited_o       (exited),
    .exit_code_o    (exit_code),
    .instret_o      (instret),
    .all_done_o     (all_done)
  );

  initial begin
    clk = 1'b0;
  end

  always #HALF_PERIOD clk = ~clk;

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic drive_idle();
    trace_valid  = '0;
    trace_pc     = '0;
    trace_insn   = '0;
    trace_wben   = '0;
    trace_wbreg  = '0;
    trace_wbdata = '0;
  endtask

  // One golden line holds the records of both cores for one cycle
  task automatic drive_record(input int rec);
    int col;
    for (int c = 0; c < NUM_CORES; c++) begin
      col = rec * NUM_COLS + c * STIM_COLS;
      trace_valid[c]                        = golden[col + COL_VALID][0];
      trace_pc[c*XLEN +: XLEN]              = golden[col + COL_PC];
      trace_insn[c*XLEN +: XLEN]            = golden[col + COL_INSN];
      trace_wben[c]                         = golden[col + COL_WBEN][0];
      trace_wbreg[c*REG_IDX_W +: REG_IDX_W] = golden[col + COL_WBREG][REG_IDX_W-1:0];
      trace_wbdata[c*XLEN +: XLEN]          = golden[col + COL_WBDATA];
    end
  endtask

  task automatic compare_outputs(input int rec);
    int    col;
    string tag;
    for (int c = 0; c < NUM_CORES; c++) begin
      col = rec * NUM_COLS + EXP_BASE + c * EXP_COLS;
      tag = $sformatf("record %0d core %0d", rec, c);
      check({tag, " putc_valid"}, golden[col + EXP_PUTC], putc_valid[c]);
      check({tag, " putc_char"}, golden[col + EXP_CHAR], putc_char[c*CHAR_W +: CHAR_W]);
      check({tag, " exited"}, golden[col + EXP_EXITED], exited[c]);
      check({tag, " exit_code"}, golden[col + EXP_CODE], exit_code[c*XLEN +: XLEN]);
      check({tag, " instret"}, golden[col + EXP_INSTRET],
            instret[c*INSTRET_W +: INSTRET_W]);
    end
    check($sformatf("record %0d all_done", rec), golden[rec * NUM_COLS + DONE_COL],
          all_done);
  endtask

  initial begin
    error_count = 0;
    check_count = 0;
    rst_n = 1'b0;
    drive_idle();
    $readmemh("test/trace_golden.mem", golden);
    if (golden[NUM_RECS*NUM_COLS-1] === 'x) begin
      error_count++;
      $display("golden file test/trace_golden.mem is missing or holds fewer than %0d records",
               NUM_RECS);
    end

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // Two idle cycles at the end flush the last records through the pipeline
    for (int i = 0; i < NUM_RECS + OUT_LAG; i++) begin
      @(negedge clk);
      if (i >= OUT_LAG) begin
        compare_outputs(i - OUT_LAG);
      end
      if (i < NUM_RECS) begin
        drive_record(i);
      end else begin
        drive_idle();
      end
    end

    while (!all_done) begin
      @(negedge clk);
    end

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog in case all_done never rises
  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    error_count++;
    $display("timeout: all_done_o did not rise within %0d cycles", CYCLE_LIMIT);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    $display("sim failed");
    $finish;
  end

endmodule : tb_trace_monitor

`default_nettype wire

// ==== rtl/trace_monitor_top.sv ====
`timescale 1ns/1ns
`default_nettype none

// Trace monitor for all cores plus the global termination flag
module trace_monitor_top
  import trace_pkg::*;
  import sim_event_pkg::*;
(
  input  wire logic                           clk_i,
  input  wire logic                           rst_n_i,
  input  wire logic [NUM_CORES-1:0]           trace_valid_i,
  input  wire logic [NUM_CORES*XLEN-1:0]      trace_pc_i,
  input  wire logic [NUM_CORES*XLEN-1:0]      trace_insn_i,
  input  wire logic [NUM_CORES-1:0]           trace_wben_i,
  input  wire logic [NUM_CORES*REG_IDX_W-1:0] trace_wbreg_i,
  input  wire logic [NUM_CORES*XLEN-1:0]      trace_wbdata_i,
  output logic      [NUM_CORES-1:0]           putc_valid_o,
  output logic      [NUM_CORES*CHAR_W-1:0]    putc_char_o,
  output logic      [NUM_CORES-1:0]           exited_o,
  output logic      [NUM_CORES*XLEN-1:0]      exit_code_o,
  output logic      [NUM_CORES*INSTRET_W-1:0] instret_o,
  output logic                                all_done_o
);

  genvar c;

  // Core c occupies slice c of every flattened array
  generate
    for (c = 0; c < NUM_CORES; c = c + 1) begin : gen_core_mon
      core_trace_monitor core_trace_monitor_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .trace_valid_i  (trace_valid_i[c]),
        .trace_pc_i     (trace_pc_i[c*XLEN +: XLEN]),
        .trace_insn_i   (trace_insn_i[c*XLEN +: XLEN]),
        .trace_wben_i   (trace_wben_i[c]),
        .trace_wbreg_i  (trace_wbreg_i[c*REG_IDX_W +: REG_IDX_W]),
        .trace_wbdata_i (trace_wbdata_i[c*XLEN +: XLEN]),
        .putc_valid_o   (putc_valid_o[c]),
        .putc_char_o    (putc_char_o[c*CHAR_W +: CHAR_W]),
        .exited_o       (exited_o[c]),
        .exit_code_o    (exit_code_o[c*XLEN +: XLEN]),
        .instret_o      (instret_o[c*INSTRET_W +: INSTRET_W])
      );
    end
  endgenerate

  termination_tracker termination_tracker_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .exited_i   (exited_o),
    .all_done_o (all_done_o)
  );

endmodule : trace_monitor_top

`default_nettype wire

// ==== rtl/termination_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

// Raises a sticky level once every core has exited
module termination_tracker
  import trace_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic [NUM_CORES-1:0] exited_i,
  output logic                      all_done_o
);

  logic [NUM_CORES-1:0] seen_q;
  logic [NUM_CORES-1:0] seen_next;

  // Remember each core that has exited, even if its flag were to drop
  assign seen_next = seen_q | exited_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      seen_q <= '0;
    end else begin
      seen_q <= seen_next;
    end
  end

  // One cycle after the last core reports exit
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      all_done_o <= 1'b0;
    end else if (&seen_next) begin
      all_done_o <= 1'b1;
    end
  end

endmodule : termination_tracker

`default_nettype wire

// ==== rtl/core_trace_monitor.sv ====
`timescale 1ns/1ns
`default_nettype none

// Per-core monitor that turns decoded events and the r3 copy into
// putc pulses, exit state and an instruction count
module core_trace_monitor
  import trace_pkg::*;
  import sim_event_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 trace_valid_i,
  input  wire logic [XLEN-1:0]      trace_pc_i,
  input  wire logic [XLEN-1:0]      trace_insn_i,
  input  wire logic                 trace_wben_i,
  input  wire logic [REG_IDX_W-1:0] trace_wbreg_i,
  input  wire logic [XLEN-1:0]      trace_wbdata_i,
  output logic                      putc_valid_o,
  output logic      [CHAR_W-1:0]    putc_char_o,
  output logic                      exited_o,
  output logic      [XLEN-1:0]      exit_code_o,
  output logic      [INSTRET_W-1:0] instret_o
);

  logic [XLEN-1:0] r3;
  logic            exit_ev;
  logic            putc_ev;
  logic            count_stop;

  r3_shadow r3_shadow_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .valid_i  (trace_valid_i),
    .wben_i   (trace_wben_i),
    .wbreg_i  (trace_wbreg_i),
    .wbdata_i (trace_wbdata_i),
    .r3_o     (r3)
  );

  sim_event_decode sim_event_decode_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .valid_i   (trace_valid_i),
    .insn_i    (trace_insn_i),
    .exit_ev_o (exit_ev),
    .putc_ev_o (putc_ev)
  );

  // Event strobes line up with r3, which already holds every earlier write
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      putc_valid_o <= 1'b0;
      putc_char_o  <= '0;
    end else begin
      putc_valid_o <= putc_ev & ~exited_o;
      if (putc_ev && !exited_o) begin
        putc_char_o <= r3[CHAR_W-1:0];
      end
    end
  end

  // Exit is sticky, the first exit code wins
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exited_o    <= 1'b0;
      exit_code_o <= '0;
    end else if (exit_ev && !exited_o) begin
      exited_o    <= 1'b1;
      exit_code_o <= r3;
    end
  end

  // The exit strobe lags its record by one cycle, so it blocks the next record too
  assign count_stop = exited_o | exit_ev;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      instret_o <= '0;
    end else if (trace_valid_i && !count_stop) begin
      instret_o <= instret_o + 1'b1;
    end
  end

endmodule : core_trace_monitor

`default_nettype wire

// ==== rtl/sim_event_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

// Spots simulator event instructions in one retire stream
// Event strobes come out one cycle after the retire edge
module sim_event_decode
  import trace_pkg::*;
  import sim_event_pkg::*;
(
  input  wire logic            clk_i,
  input  wire logic            rst_n_i,
  input  wire logic            valid_i,
  input  wire logic [XLEN-1:0] insn_i,
  output logic                 exit_ev_o,
  output logic                 putc_ev_o
);

  logic [OPCODE_W-1:0]  opcode;
  logic [REG_IDX_W-1:0] rd;
  logic [FUNCT3_W-1:0]  funct3;
  logic [REG_IDX_W-1:0] rs1;
  logic [IMM_W-1:0]     imm;

  logic is_nop_imm;
  logic exit_hit;
  logic putc_hit;

  // I-type field split
  assign opcode = insn_i[6:0];
  assign rd     = insn_i[11:7];
  assign funct3 = insn_i[14:12];
  assign rs1    = insn_i[19:15];
  assign imm    = insn_i[31:20];

  // addi x0, x0, imm with any immediate
  assign is_nop_imm = valid_i
                    & (opcode == EV_OPCODE)
                    & (funct3 == EV_FUNCT3_ADDI)
                    & (rd == '0)
                    & (rs1 == '0);

  // Immediates are distinct, so at most one hit per record
  assign exit_hit = is_nop_imm & (imm == EV_EXIT);
  assign putc_hit = is_nop_imm & (imm == EV_PUTC);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_ev_o <= 1'b0;
      putc_ev_o <= 1'b0;
    end else begin
      exit_ev_o <= exit_hit;
      putc_ev_o <= putc_hit;
    end
  end

endmodule : sim_event_decode

`default_nettype wire

// ==== rtl/r3_shadow.sv ====
`timescale 1ns/1ns
`default_nettype none

// Keeps the last value written to x3 by one core
module r3_shadow
  import trace_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 valid_i,
  input  wire logic                 wben_i,
  input  wire logic [REG_IDX_W-1:0] wbreg_i,
  input  wire logic [XLEN-1:0]      wbdata_i,
  output logic      [XLEN-1:0]      r3_o
);

  logic r3_write;

  // Only a retired record with write-back to x3 updates the copy
  assign r3_write = valid_i & wben_i & (wbreg_i == R3_IDX);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r3_o <= '0;
    end else if (r3_write) begin
      r3_o <= wbdata_i;
    end
  end

endmodule : r3_shadow

`default_nettype wire

// ==== common/sim_event_pkg.sv ====
`default_nettype none

// Encoding of the simulator control instructions
// Software signals the simulator with "addi x0, x0, imm", an architectural nop
package sim_event_pkg;

  // Instruction field widths of the I-type format
  localparam int OPCODE_W = 7;
  localparam int FUNCT3_W = 3;
  localparam int IMM_W    = 12;

  // OP-IMM major opcode
  localparam logic [OPCODE_W-1:0] EV_OPCODE = 7'b0010011;

  // ADDI within OP-IMM
  localparam logic [FUNCT3_W-1:0] EV_FUNCT3_ADDI = 3'b000;

  // Immediate values that select the event
  localparam logic [IMM_W-1:0] EV_EXIT = 12'd1;  // core exit, code in r3
  localparam logic [IMM_W-1:0] EV_PUTC = 12'd4;  // print low byte of r3

  // Character width of the putc output
  localparam int CHAR_W = 8;

endpackage : sim_event_pkg

`default_nettype wire

// ==== common/trace_pkg.sv ====
`default_nettype none

// Retire trace record layout shared by every trace monitor block
package trace_pkg;

  // Number of cores whose retire streams are observed
  localparam int NUM_CORES = 2;

  // Width of pc, instruction and write-back data words (RV32)
  localparam int XLEN = 32;

  // Register file index width, x0 to x31
  localparam int REG_IDX_W = 5;

  // Software passes event arguments in x3, so only that register is shadowed
  localparam logic [REG_IDX_W-1:0] R3_IDX = 5'd3;

  // Retired instruction counter width per core
  // Wraps silently, enough for the short test programs
  localparam int INSTRET_W = 16;

endpackage : trace_pkg

`default_nettype wire
